/* common/apbPkg.sv */
package apbPkg;

	typedef logic [9:0] apbAddrT;
	typedef logic [31:0] apbDataT;

	// Control and status registers
	localparam apbAddrT ctrlAddr = 10'h000;
	localparam apbAddrT statusAddr = 10'h004;

	// Operand and result windows, one word per entry
	localparam apbAddrT activationBase = 10'h040;
	localparam apbAddrT biasBase = 10'h080;
	localparam apbAddrT resultBase = 10'h0C0;
	localparam apbAddrT weightBase = 10'h100;

	localparam int startBit = 0;
	localparam int busyBit = 0;
	localparam int doneBit = 1;

endpackage

/* common/layerPkg.sv */
package layerPkg;

	// Operand and result types of the layer datapath
	typedef logic signed [7:0] activationT;
	typedef logic signed [7:0] weightT;
	typedef logic signed [7:0] biasT;

	// Wide enough for the bias plus fifteen full-scale products
	typedef logic signed [19:0] accT;

	typedef logic [15:0] resultT;

	localparam int numInputs = 15;
	localparam int numNeurons = 4;

	// Weight (n,i) sits at n*16 + i, so one row per neuron
	localparam int weightDepth = 64;

	typedef logic [3:0] inputIndexT;
	typedef logic [1:0] neuronIndexT;
	typedef logic [5:0] weightIndexT;

	localparam int resultMax = 65535;

endpackage

/* common/macBus.sv */
`timescale 1ns/1ps

interface macBus;

	// Load the bias into the accumulator
	logic clear;

	// Add one activation and weight product
	logic accumulate;

	// Clamp and write the neuron result
	logic finish;

	// High in the cycle the result is written
	logic resultValid;

	modport sequencer
	(
		output clear,
		output accumulate,
		output finish,
		input resultValid
	);

	modport accumulator
	(
		input clear,
		input accumulate,
		input finish,
		output resultValid
	);

endinterface

/* flist.f */
common/layerPkg.sv
common/apbPkg.sv
common/macBus.sv
layer/operandStore.sv
layer/indexCounter.sv
layer/neuronAccumulator.sv
layer/layerSequencer.sv
logic/apbRegs.sv
layer/denseLayer.sv
tests/denseLayer_assertions.sv
tests/denseLayerTb.sv

/* layer/denseLayer.sv */
`timescale 1ns/1ps

module denseLayer
	import layerPkg::*, apbPkg::*;
(
	input logic clk,
	input logic reset,
	input apbAddrT paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apbDataT pwdata,
	output apbDataT prdata,
	output logic pready,
	output logic pslverr
);

	logic start;
	logic busy;
	logic layerDone;
	logic lastInput;
	logic lastNeuron;
	logic counterClear;
	logic counterStep;
	inputIndexT inputIndex;
	neuronIndexT neuronIndex;
	weightIndexT weightIndex;

	logic activationWrite;
	logic weightWrite;
	logic biasWrite;
	activationT activationWriteData;
	weightT weightWriteData;
	biasT biasWriteData;
	inputIndexT hostActivationIndex;
	weightIndexT hostWeightIndex;
	neuronIndexT hostBiasIndex;
	neuronIndexT hostResultIndex;
	activationT hostActivationData;
	weightT hostWeightData;
	biasT hostBiasData;
	resultT hostResultData;

	activationT activation;
	weightT weight;
	biasT bias;
	logic resultWrite;
	resultT result;

	macBus mac ();

	apbRegs apbRegs0
	(
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.busy(busy),
		.layerDone(layerDone),
		.start(start),
		.activationWrite(activationWrite),
		.activationWriteData(activationWriteData),
		.weightWrite(weightWrite),
		.weightWriteData(weightWriteData),
		.biasWrite(biasWrite),
		.biasWriteData(biasWriteData),
		.activationIndex(hostActivationIndex),
		.activationReadData(hostActivationData),
		.weightIndex(hostWeightIndex),
		.weightReadData(hostWeightData),
		.biasIndex(hostBiasIndex),
		.biasReadData(hostBiasData),
		.resultIndex(hostResultIndex),
		.resultReadData(hostResultData)
	);

	layerSequencer layerSequencer0
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.busy(busy),
		.layerDone(layerDone),
		.lastInput(lastInput),
		.lastNeuron(lastNeuron),
		.counterClear(counterClear),
		.counterStep(counterStep),
		.bus(mac.sequencer)
	);

	indexCounter indexCounter0
	(
		.clk(clk),
		.reset(reset),
		.counterClear(counterClear),
		.counterStep(counterStep),
		.inputIndex(inputIndex),
		.neuronIndex(neuronIndex),
		.weightIndex(weightIndex),
		.lastInput(lastInput),
		.lastNeuron(lastNeuron)
	);

	neuronAccumulator neuronAccumulator0
	(
		.clk(clk),
		.reset(reset),
		.activation(activation),
		.weight(weight),
		.bias(bias),
		.bus(mac.accumulator),
		.resultWrite(resultWrite),
		.result(result)
	);

	// Port A feeds the datapath and port B serves the host
	operandStore #(.payloadT(activationT), .depth(numInputs)) activationStore
	(
		.clk(clk),
		.reset(reset),
		.writeEnable(activationWrite),
		.writeIndex(hostActivationIndex),
		.writeData(activationWriteData),
		.readIndexA(inputIndex),
		.readDataA(activation),
		.readIndexB(hostActivationIndex),
		.readDataB(hostActivationData)
	);

	operandStore #(.payloadT(weightT), .depth(weightDepth)) weightStore
	(
		.clk(clk),
		.reset(reset),
		.writeEnable(weightWrite),
		.writeIndex(hostWeightIndex),
		.writeData(weightWriteData),
		.readIndexA(weightIndex),
		.readDataA(weight),
		.readIndexB(hostWeightIndex),
		.readDataB(hostWeightData)
	);

	operandStore #(.payloadT(biasT), .depth(numNeurons)) biasStore
	(
		.clk(clk),
		.reset(reset),
		.writeEnable(biasWrite),
		.writeIndex(hostBiasIndex),
		.writeData(biasWriteData),
		.readIndexA(neuronIndex),
		.readDataA(bias),
		.readIndexB(hostBiasIndex),
		.readDataB(hostBiasData)
	);

	// The datapath only writes results, so port A stays open
	operandStore #(.payloadT(resultT), .depth(numNeurons)) resultStore
	(
		.clk(clk),
		.reset(reset),
		.writeEnable(resultWrite),
		.writeIndex(neuronIndex),
		.writeData(result),
		.readIndexA(neuronIndex),
		.readDataA(),
		.readIndexB(hostResultIndex),
		.readDataB(hostResultData)
	);

endmodule

/* layer/indexCounter.sv */
`timescale 1ns/1ps

module indexCounter
	import layerPkg::*;
(
	input logic clk,
	input logic reset,
	input logic counterClear,
	input logic counterStep,
	output inputIndexT inputIndex,
	output neuronIndexT neuronIndex,
	output weightIndexT weightIndex,
	output logic lastInput,
	output logic lastNeuron
);

	always_ff @(posedge clk)
	begin
		if (reset || counterClear)
		begin
			inputIndex <= '0;
			neuronIndex <= '0;
		end
		else if (counterStep)
		begin
			if (lastInput)
			begin
				inputIndex <= '0;
				neuronIndex <= lastNeuron ? '0 : neuronIndex + 1'b1;
			end
			else
			begin
				inputIndex <= inputIndex + 1'b1;
			end
		end
	end

	assign lastInput = inputIndex == inputIndexT'(numInputs - 1);
	assign lastNeuron = neuronIndex == neuronIndexT'(numNeurons - 1);

	// Each neuron owns a row of sixteen weight slots
	assign weightIndex = {neuronIndex, inputIndex};

endmodule

/* layer/layerSequencer.sv */
`timescale 1ns/1ps

module layerSequencer
(
	input logic clk,
	input logic reset,
	input logic start,
	output logic busy,
	output logic layerDone,
	input logic lastInput,
	input logic lastNeuron,
	output logic counterClear,
	output logic counterStep,
	macBus.sequencer bus
);

	typedef enum logic [1:0]
	{
		idleState,
		clearState,
		accumulateState,
		finishState
	} stateT;

	stateT state;
	stateT nextState;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= idleState;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			idleState:
				if (start)
					nextState = clearState;
			clearState:
				nextState = accumulateState;
			accumulateState:
				if (lastInput)
					nextState = finishState;
			finishState:
				if (bus.resultValid)
					nextState = lastNeuron ? idleState : clearState;
			default:
				nextState = idleState;
		endcase
	end

	assign bus.clear = state == clearState;
	assign bus.accumulate = state == accumulateState;
	assign bus.finish = state == finishState;

	assign busy = state != idleState;
	assign layerDone = bus.finish && bus.resultValid && lastNeuron;

	// The input index holds on the last product so the finish cycle sees this neuron
	assign counterClear = (state == idleState) && start;
	assign counterStep = (bus.accumulate && !lastInput) || (bus.finish && bus.resultValid);

endmodule

/* layer/neuronAccumulator.sv */
`timescale 1ns/1ps

module neuronAccumulator
	import layerPkg::*;
(
	input logic clk,
	input logic reset,
	input activationT activation,
	input weightT weight,
	input biasT bias,
	macBus.accumulator bus,
	output logic resultWrite,
	output resultT result
);

	accT acc;
	logic signed [15:0] product;

	assign product = activation * weight;

	always_ff @(posedge clk)
	begin
		if (reset)
			acc <= '0;
		else if (bus.clear)
			acc <= accT'(bias);
		else if (bus.accumulate)
			acc <= acc + accT'(product);
	end

	// ReLU first, then saturate to the unsigned output range
	always_comb
	begin
		if (acc < 0)
			result = '0;
		else if (acc > resultMax)
			result = resultT'(resultMax);
		else
			result = acc[15:0];
	end

	assign resultWrite = bus.finish;
	assign bus.resultValid = resultWrite;

endmodule

/* layer/operandStore.sv */
`timescale 1ns/1ps

module operandStore
#(
	parameter type payloadT = logic [7:0],
	parameter int depth = 4
)
(
	input logic clk,
	input logic reset,
	input logic writeEnable,
	input logic [$clog2(depth)-1:0] writeIndex,
	input payloadT writeData,
	input logic [$clog2(depth)-1:0] readIndexA,
	output payloadT readDataA,
	input logic [$clog2(depth)-1:0] readIndexB,
	output payloadT readDataB
);

	payloadT entries [depth];

	always_ff @(posedge clk)
	begin
		if (reset)
			entries <= '{default: '0};
		else if (writeEnable)
			entries[writeIndex] <= writeData;
	end

	// Both ports read in the same cycle as their index
	assign readDataA = entries[readIndexA];
	assign readDataB = entries[readIndexB];

endmodule

/* logic/apbRegs.sv */
`timescale 1ns/1ps

module apbRegs
	import layerPkg::*, apbPkg::*;
(
	input logic clk,
	input logic reset,
	input apbAddrT paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apbDataT pwdata,
	output apbDataT prdata,
	output logic pready,
	output logic pslverr,
	input logic busy,
	input logic layerDone,
	output logic start,
	output logic activationWrite,
	output activationT activationWriteData,
	output logic weightWrite,
	output weightT weightWriteData,
	output logic biasWrite,
	output biasT biasWriteData,
	output inputIndexT activationIndex,
	input activationT activationReadData,
	output weightIndexT weightIndex,
	input weightT weightReadData,
	output neuronIndexT biasIndex,
	input biasT biasReadData,
	output neuronIndexT resultIndex,
	input resultT resultReadData
);

	logic access;
	logic writeAccess;
	logic wordAligned;
	logic ctrlHit;
	logic statusHit;
	logic activationHit;
	logic weightHit;
	logic biasHit;
	logic resultHit;
	logic operandHit;
	logic mapped;
	logic startRequest;
	logic doneFlag;

	assign access = psel && penable;
	assign writeAccess = access && pwrite;

	assign wordAligned = paddr[1:0] == 2'b00;
	assign ctrlHit = paddr == ctrlAddr;
	assign statusHit = paddr == statusAddr;
	assign activationHit = wordAligned && paddr[9:6] == activationBase[9:6]
		&& paddr[5:2] < 4'(numInputs);
	assign biasHit = wordAligned && paddr[9:6] == biasBase[9:6]
		&& paddr[5:2] < 4'(numNeurons);
	assign resultHit = wordAligned && paddr[9:6] == resultBase[9:6]
		&& paddr[5:2] < 4'(numNeurons);
	// Slots 15, 31, 47 and 63 are gaps in the weight rows
	assign weightHit = wordAligned && paddr[9:8] == weightBase[9:8]
		&& paddr[5:2] < 4'(numInputs);

	assign operandHit = activationHit || weightHit || biasHit;
	assign mapped = ctrlHit || statusHit || operandHit || resultHit;

	assign activationIndex = paddr[5:2];
	assign weightIndex = paddr[7:2];
	assign biasIndex = paddr[3:2];
	assign resultIndex = paddr[3:2];

	assign startRequest = writeAccess && ctrlHit && pwdata[startBit];
	assign start = startRequest && !busy;

	// Operands are frozen while the layer runs
	assign activationWrite = writeAccess && activationHit && !busy;
	assign weightWrite = writeAccess && weightHit && !busy;
	assign biasWrite = writeAccess && biasHit && !busy;
	assign activationWriteData = pwdata[7:0];
	assign weightWriteData = pwdata[7:0];
	assign biasWriteData = pwdata[7:0];

	assign pready = 1'b1;
	assign pslverr = access && (!mapped
		|| (pwrite && (statusHit || resultHit || (operandHit && busy)))
		|| (startRequest && busy));

	always_ff @(posedge clk)
	begin
		if (reset || start)
			doneFlag <= 1'b0;
		else if (layerDone)
			doneFlag <= 1'b1;
	end

	always_comb
	begin
		prdata = '0;
		if (statusHit)
		begin
			prdata[busyBit] = busy;
			prdata[doneBit] = doneFlag;
		end
		else if (activationHit)
			prdata = {{24{activationReadData[7]}}, activationReadData};
		else if (weightHit)
			prdata = {{24{weightReadData[7]}}, weightReadData};
		else if (biasHit)
			prdata = {{24{biasReadData[7]}}, biasReadData};
		else if (resultHit)
			prdata = {16'b0, resultReadData};
	end

endmodule

/* tests/denseLayerTb.sv */
`timescale 1ns/1ps

module denseLayerTb
	import layerPkg::*, apbPkg::*;
();

	// Each run writes and reads back every operand, polls status and reads the results
	localparam int transferCycles = 3;
	localparam int transfersPerRun = 200;
	localparam int runCount = 22;
	localparam int cycleLimit = runCount * (transfersPerRun * transferCycles + 100);

	localparam int resultKind = 0;
	localparam int dataKind = 1;
	localparam int errorKind = 2;

	logic clk;
	logic reset;
	apbAddrT paddr;
	logic psel;
	logic penable;
	logic pwrite;
	apbDataT pwdata;
	apbDataT prdata;
	logic pready;
	logic pslverr;

	activationT acts [numInputs];
	weightT wts [numNeurons][numInputs];
	biasT biases [numNeurons];

	int kindQ [$];
	apbDataT expectedQ [$];
	apbDataT actualQ [$];
	string whatQ [$];
	logic stimulusDone;
	int cycleCount;

	denseLayer dut0
	(
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		cycleCount = 0;
		forever
		begin
			@(posedge clk);
			cycleCount++;
			if (cycleCount >= cycleLimit)
			begin
				$display("Timeout: the test did not finish within %0d cycles", cycleLimit);
				$display("TESTS FAILED");
				$fatal(1, "Simulation stopped after the cycle limit");
			end
		end
	end

	// Expected output from the bias and the products after ReLU and clamp
	function automatic resultT neuronRef(int n);
		int sum;
		sum = int'(biases[n]);
		for (int i = 0; i < numInputs; i++)
			sum += int'(acts[i]) * int'(wts[n][i]);
		if (sum < 0)
			return '0;
		else if (sum > resultMax)
			return resultT'(resultMax);
		return resultT'(sum);
	endfunction

	function automatic apbDataT signExtended(logic signed [7:0] value);
		return {{24{value[7]}}, value};
	endfunction

	function automatic apbAddrT activationAddr(int i);
		return apbAddrT'(activationBase + 4 * i);
	endfunction

	function automatic apbAddrT weightAddr(int n, int i);
		return apbAddrT'(weightBase + 4 * (16 * n + i));
	endfunction

	function automatic apbAddrT biasAddr(int n);
		return apbAddrT'(biasBase + 4 * n);
	endfunction

	function automatic apbAddrT resultAddr(int n);
		return apbAddrT'(resultBase + 4 * n);
	endfunction

	task automatic checkResult(resultT expected, resultT actual, string what);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s: expected %0d, got %0d", $time, what,
				expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "Result mismatch");
		end
	endtask

	task automatic checkData(apbDataT expected, apbDataT actual, string what);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s: expected %08h, got %08h", $time, what,
				expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "Read data mismatch");
		end
	endtask

	task automatic checkError(logic expected, logic actual, string what);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s: expected pslverr %0b, got %0b", $time, what,
				expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "Slave error mismatch");
		end
	endtask

	task automatic queueCheck(int kind, apbDataT expected, apbDataT actual, string what);
		kindQ.push_back(kind);
		expectedQ.push_back(expected);
		actualQ.push_back(actual);
		whatQ.push_back(what);
	endtask

	// Drains the queued observations once per cycle
	initial
	begin
		int kind;
		apbDataT expected;
		apbDataT actual;
		string what;
		forever
		begin
			@(negedge clk);
			while (kindQ.size() > 0)
			begin
				kind = kindQ.pop_front();
				expected = expectedQ.pop_front();
				actual = actualQ.pop_front();
				what = whatQ.pop_front();
				case (kind)
					resultKind: checkResult(resultT'(expected), resultT'(actual), what);
					dataKind: checkData(expected, actual, what);
					default: checkError(expected[0], actual[0], what);
				endcase
			end
			if (dut0.assertions0.failCount != 0)
			begin
				$display("A bound assertion on the DUT failed before %0t ns", $time);
				$display("TESTS FAILED");
				$fatal(1, "Assertion failure");
			end
			else if (stimulusDone)
			begin
				$display("TESTS PASSED");
				$finish;
			end
		end
	end

	task automatic apbWrite(apbAddrT addr, apbDataT data, output logic err);
		@(posedge clk);
		#2;
		paddr = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#2;
		penable = 1'b1;
		@(negedge clk);
		while (pready !== 1'b1)
			@(negedge clk);
		err = pslverr;
		@(posedge clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbRead(apbAddrT addr, output apbDataT data, output logic err);
		@(posedge clk);
		#2;
		paddr = addr;
		pwrite = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#2;
		penable = 1'b1;
		@(negedge clk);
		while (pready !== 1'b1)
			@(negedge clk);
		data = prdata;
		err = pslverr;
		@(posedge clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic storeWord(apbAddrT addr, apbDataT data, logic expectErr, string what);
		logic err;
		apbWrite(addr, data, err);
		queueCheck(errorKind, apbDataT'(expectErr), apbDataT'(err), what);
	endtask

	task automatic verifyWord(apbAddrT addr, apbDataT expected, logic expectErr, string what);
		apbDataT data;
		logic err;
		apbRead(addr, data, err);
		queueCheck(dataKind, expected, data, what);
		queueCheck(errorKind, apbDataT'(expectErr), apbDataT'(err), what);
	endtask

	task automatic loadOperands();
		for (int i = 0; i < numInputs; i++)
			storeWord(activationAddr(i), signExtended(acts[i]), 1'b0, "activation write");
		for (int n = 0; n < numNeurons; n++)
			for (int i = 0; i < numInputs; i++)
				storeWord(weightAddr(n, i), signExtended(wts[n][i]), 1'b0, "weight write");
		for (int n = 0; n < numNeurons; n++)
			storeWord(biasAddr(n), signExtended(biases[n]), 1'b0, "bias write");
		for (int i = 0; i < numInputs; i++)
			verifyWord(activationAddr(i), signExtended(acts[i]), 1'b0, "activation readback");
		for (int n = 0; n < numNeurons; n++)
			for (int i = 0; i < numInputs; i++)
				verifyWord(weightAddr(n, i), signExtended(wts[n][i]), 1'b0, "weight readback");
		for (int n = 0; n < numNeurons; n++)
			verifyWord(biasAddr(n), signExtended(biases[n]), 1'b0, "bias readback");
	endtask

	// The first status read after a start must show busy with done cleared
	task automatic startLayer();
		storeWord(ctrlAddr, 32'h1, 1'b0, "start");
		verifyWord(statusAddr, apbDataT'(1) << busyBit, 1'b0, "status after start");
	endtask

	task automatic awaitDone();
		apbDataT status;
		logic err;
		status = '0;
		while (!status[doneBit])
		begin
			apbRead(statusAddr, status, err);
			queueCheck(errorKind, '0, apbDataT'(err), "status poll");
		end
		queueCheck(dataKind, apbDataT'(1) << doneBit, status, "status at end of run");
	endtask

	task automatic compareResults();
		apbDataT data;
		logic err;
		for (int n = 0; n < numNeurons; n++)
		begin
			apbRead(resultAddr(n), data, err);
			queueCheck(resultKind, apbDataT'(neuronRef(n)), data, $sformatf("result %0d", n));
			queueCheck(errorKind, '0, apbDataT'(err), $sformatf("result %0d read", n));
		end
	endtask

	task automatic randomizeOperands();
		for (int i = 0; i < numInputs; i++)
			acts[i] = activationT'($urandom());
		for (int n = 0; n < numNeurons; n++)
		begin
			biases[n] = biasT'($urandom());
			for (int i = 0; i < numInputs; i++)
				wts[n][i] = weightT'($urandom());
		end
	endtask

	task automatic fillOperands(activationT act, weightT wt, biasT bias);
		for (int i = 0; i < numInputs; i++)
			acts[i] = act;
		for (int n = 0; n < numNeurons; n++)
		begin
			biases[n] = bias;
			for (int i = 0; i < numInputs; i++)
				wts[n][i] = wt;
		end
	endtask

	initial
	begin
		void'($urandom(32'h5d05_c895));
		stimulusDone = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		fillOperands('0, '0, '0);
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;

		verifyWord(statusAddr, '0, 1'b0, "status after reset");
		compareResults();

		for (int run = 0; run < 16; run++)
		begin
			randomizeOperands();
			loadOperands();
			startLayer();
			awaitDone();
			compareResults();
		end

		// Operands are frozen and a second start is refused while busy
		randomizeOperands();
		loadOperands();
		startLayer();
		storeWord(activationAddr(3), signExtended(~acts[3]), 1'b1,
			"activation write while busy");
		verifyWord(activationAddr(3), signExtended(acts[3]), 1'b0,
			"activation kept while busy");
		storeWord(weightAddr(1, 2), signExtended(~wts[1][2]), 1'b1, "weight write while busy");
		storeWord(biasAddr(0), signExtended(~biases[0]), 1'b1, "bias write while busy");
		storeWord(ctrlAddr, 32'h1, 1'b1, "second start while busy");
		awaitDone();
		compareResults();

		fillOperands(8'sd127, 8'sd127, 8'sd127);
		loadOperands();
		startLayer();
		awaitDone();
		compareResults();

		fillOperands(8'sd127, -8'sd128, -8'sd128);
		loadOperands();
		startLayer();
		awaitDone();
		compareResults();

		for (int i = 0; i < numInputs; i++)
			acts[i] = activationT'(i - 7);
		for (int n = 0; n < numNeurons; n++)
		begin
			biases[n] = biasT'(20 * n - 5);
			for (int i = 0; i < numInputs; i++)
				wts[n][i] = weightT'((i % 3) - 1 + n);
		end
		loadOperands();
		startLayer();
		awaitDone();
		compareResults();

		storeWord(resultAddr(1), 32'h1234, 1'b1, "write to result");
		storeWord(statusAddr, 32'h3, 1'b1, "write to status");
		storeWord(10'h200, 32'hFF, 1'b1, "write to unmapped address");
		storeWord(weightAddr(0, 15), 32'h11, 1'b1, "write to weight gap");
		verifyWord(10'h200, '0, 1'b1, "unmapped read");
		verifyWord(10'h3FC, '0, 1'b1, "unmapped read at top");
		verifyWord(10'h042, '0, 1'b1, "misaligned read");
		compareResults();

		// Only neuron 2 sees a new bias
		biases[2] = -8'sd5;
		storeWord(biasAddr(2), signExtended(biases[2]), 1'b0, "bias update");
		startLayer();
		awaitDone();
		compareResults();

		repeat (2) @(posedge clk);
		stimulusDone = 1'b1;
	end

endmodule

/* tests/denseLayer_assertions.sv */
`timescale 1ns/1ps

module denseLayer_assertions
(
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic busy,
	input logic done,
	input logic resultValid
);

	int unsigned failCount = 0;

	// No wait states in this slave
	readyAlwaysHigh: assert property (@(posedge clk) disable iff (reset) pready)
		else
		begin
			failCount++;
			$error("pready dropped low");
		end

	errorOnlyInAccess: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> psel && penable)
		else
		begin
			failCount++;
			$error("pslverr raised outside an access phase");
		end

	resultOnlyWhileBusy: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> busy)
		else
		begin
			failCount++;
			$error("resultValid pulsed while the layer was idle");
		end

	busyExcludesDone: assert property (@(posedge clk) disable iff (reset)
		!(busy && done))
		else
		begin
			failCount++;
			$error("busy and done set together");
		end

endmodule

bind denseLayer denseLayer_assertions assertions0
(
	.clk(clk),
	.reset(reset),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.busy(busy),
	.done(apbRegs0.doneFlag),
	.resultValid(mac.resultValid)
);
